// File: files.f
hw/texture_pkg.sv
hw/window_if.sv
hw/bin_port_if.sv
hw/window_buffer.sv
hw/lbp_encoder.sv
hw/histogram_accumulator.sv
hw/bin_arbiter.sv
hw/histogram_readout.sv
hw/texture_top.sv
verification/texture_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= files.f
TB_TOP     ?= texture_tb
RTL_TOP    ?= texture_top
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --timing --assert
LINT_FLAGS ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: verification/texture_tb.sv
`timescale 1ns/1ns

module texture_tb;
  import texture_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_FRAMES = 6;
  localparam int NUM_READOUTS = 7;
  localparam int CLEAR_CYCLES = 400;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * IMG_ROWS * IMG_COLS * 4
                                 + NUM_READOUTS * NUM_BINS * 6 + CLEAR_CYCLES;

  // neighbor steps E, NE, N, NW, W, SW, S, SE with north at the lower row
  localparam int ROW_STEP [8] = '{0, -1, -1, -1, 0, 1, 1, 1};
  localparam int COL_STEP [8] = '{1, 1, 0, -1, -1, -1, 0, 1};

  logic   clk;
  logic   rst_n;
  pixel_t pixel_i;
  logic   pixel_valid_i;
  logic   read_en_i;
  logic   frame_done_o;
  count_t bin_count_o;
  logic   bin_valid_o;
  logic   read_done_o;

  logic [31:0] lfsr_q;
  int frame_pix [IMG_ROWS][IMG_COLS];
  int exp_hist [NUM_BINS];
  int got_q [$];
  int done_cnt;
  int frame_cnt;

  texture_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .read_en_i     (read_en_i),
    .frame_done_o  (frame_done_o),
    .bin_count_o   (bin_count_o),
    .bin_valid_o   (bin_valid_o),
    .read_done_o   (read_done_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // collect readout data and count the pulses
  initial begin
    done_cnt = 0;
    frame_cnt = 0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (bin_valid_o) begin
        got_q.push_back(int'(bin_count_o));
      end
      if (read_done_o) begin
        done_cnt = done_cnt + 1;
      end
      if (frame_done_o) begin
        frame_cnt = frame_cnt + 1;
      end
    end
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic int unsigned take_bits(input int n);
    int unsigned val;
    logic fb;
    val = 0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val = (val << 1) | int'(fb);
    end
    return val;
  endfunction

  // uniform patterns give their popcount, the rest map to 9
  function automatic int uniform_code(input logic [7:0] pat);
    int flips;
    int ones;
    flips = 0;
    ones = 0;
    for (int k = 0; k < 8; k++) begin
      if (pat[k] != pat[(k + 1) % 8]) begin
        flips++;
      end
      if (pat[k]) begin
        ones++;
      end
    end
    if (flips > 2) begin
      return 9;
    end
    return ones;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // reference histogram over every full window of the stored frame
  task automatic add_frame_to_model();
    int center;
    int sum;
    int ci;
    int r1 [8];
    int r2 [8];
    logic [7:0] ni_pat;
    logic [7:0] rd_pat;
    for (int r = 2; r <= IMG_ROWS - 3; r++) begin
      for (int c = 2; c <= IMG_COLS - 3; c++) begin
        center = frame_pix[r][c];
        sum = 0;
        for (int k = 0; k < 8; k++) begin
          r1[k] = frame_pix[r + ROW_STEP[k]][c + COL_STEP[k]];
          r2[k] = frame_pix[r + 2 * ROW_STEP[k]][c + 2 * COL_STEP[k]];
          sum += r2[k];
        end
        for (int k = 0; k < 8; k++) begin
          ni_pat[k] = (8 * r2[k] >= sum);
          rd_pat[k] = (r2[k] >= r1[k]);
        end
        ci = (center >= CI_THRESHOLD) ? 1 : 0;
        exp_hist[ci * 100 + uniform_code(ni_pat) * 10 + uniform_code(rd_pat)]++;
      end
    end
  endtask

  task automatic send_frame(input string name, input bit flat, input int level);
    int gap;
    int start;
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        frame_pix[r][c] = flat ? level : int'(take_bits(8));
      end
    end
    start = frame_cnt;
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        @(negedge clk);
        pixel_i = pixel_t'(frame_pix[r][c]);
        pixel_valid_i = 1'b1;
        @(negedge clk);
        pixel_valid_i = 1'b0;
        // 1 to 3 idle cycles before the next strobe
        gap = 1 + int'(take_bits(2) % 3);
        repeat (gap - 1) @(negedge clk);
      end
    end
    while (frame_cnt == start) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    check_value({name, " frame_done pulses"}, 1, frame_cnt - start);
    add_frame_to_model();
  endtask

  // full readout compared bin by bin, model is cleared like the memory
  task automatic run_readout(input string name, input bit toggle, output int total);
    int start_done;
    got_q.delete();
    start_done = done_cnt;
    @(negedge clk);
    read_en_i = 1'b1;
    while (done_cnt == start_done) begin
      @(negedge clk);
      if (toggle) begin
        read_en_i = (take_bits(2) != 0);
      end
    end
    read_en_i = 1'b0;
    repeat (4) @(negedge clk);
    check_value({name, " valid strobes"}, NUM_BINS, got_q.size());
    check_value({name, " read_done pulses"}, 1, done_cnt - start_done);
    total = 0;
    for (int b = 0; b < NUM_BINS; b++) begin
      check_value($sformatf("%s bin %0d", name, b), exp_hist[b], got_q[b]);
      total += got_q[b];
      exp_hist[b] = 0;
    end
  endtask

  initial begin
    int total;
    lfsr_q = 32'h9ff823e6;
    rst_n = 1'b0;
    pixel_i = '0;
    pixel_valid_i = 1'b0;
    read_en_i = 1'b0;
    for (int b = 0; b < NUM_BINS; b++) begin
      exp_hist[b] = 0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("reset frame_done_o", 0, int'(frame_done_o));
    check_value("reset bin_valid_o", 0, int'(bin_valid_o));
    check_value("reset read_done_o", 0, int'(read_done_o));

    // let the clear sweep finish
    repeat (NUM_BINS + 10) @(negedge clk);
    run_readout("empty readout", 1'b0, total);
    check_value("empty readout total", 0, total);

    send_frame("random frame", 1'b0, 0);
    run_readout("random readout", 1'b0, total);
    check_value("random readout total", 144, total);
    run_readout("second readout", 1'b0, total);
    check_value("second readout total", 0, total);

    send_frame("flat 200 frame", 1'b1, 200);
    run_readout("flat 200 readout", 1'b0, total);
    check_value("flat 200 bin 188", 144, got_q[188]);
    send_frame("flat 50 frame", 1'b1, 50);
    run_readout("flat 50 readout", 1'b0, total);
    check_value("flat 50 bin 88", 144, got_q[88]);

    // read enable dropped at random points
    send_frame("paced frame", 1'b0, 0);
    run_readout("paced readout", 1'b1, total);
    check_value("paced readout total", 144, total);

    send_frame("first of pair", 1'b0, 0);
    send_frame("second of pair", 1'b0, 0);
    run_readout("pair readout", 1'b0, total);
    check_value("pair readout total", 288, total);

    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired before the tests finished");
  end

endmodule

// File: hw/texture_top.sv
`timescale 1ns/1ns

module texture_top (
  input  logic                clk,
  input  logic                rst_n,
  input  texture_pkg::pixel_t pixel_i,
  input  logic                pixel_valid_i,
  input  logic                read_en_i,
  output logic                frame_done_o,
  output texture_pkg::count_t bin_count_o,
  output logic                bin_valid_o,
  output logic                read_done_o
);
  import texture_pkg::*;

  window_if   win_bus ();
  bin_port_if accum_port ();
  bin_port_if readout_port ();

  bin_addr_t bin;
  logic      bin_valid;
  logic      bin_last;

  window_buffer u_window_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .win           (win_bus.source)
  );

  lbp_encoder u_lbp_encoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .win         (win_bus.sink),
    .bin_o       (bin),
    .bin_valid_o (bin_valid),
    .bin_last_o  (bin_last)
  );

  histogram_accumulator u_histogram_accumulator (
    .clk          (clk),
    .rst_n        (rst_n),
    .bin_i        (bin),
    .bin_valid_i  (bin_valid),
    .bin_last_i   (bin_last),
    .mem          (accum_port.requester),
    .frame_done_o (frame_done_o)
  );

  histogram_readout u_histogram_readout (
    .clk         (clk),
    .rst_n       (rst_n),
    .read_en_i   (read_en_i),
    .mem         (readout_port.requester),
    .bin_count_o (bin_count_o),
    .bin_valid_o (bin_valid_o),
    .read_done_o (read_done_o)
  );

  bin_arbiter u_bin_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .accum   (accum_port.target),
    .readout (readout_port.target)
  );

endmodule

// File: hw/histogram_readout.sv
`timescale 1ns/1ns

module histogram_readout (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                read_en_i,
  bin_port_if.requester       mem,
  output texture_pkg::count_t bin_count_o,
  output logic                bin_valid_o,
  output logic                read_done_o
);
  import texture_pkg::*;

  readout_state_e state_q;
  bin_addr_t      addr_q;
  logic           access;

  // requests only while enabled, address holds through a pause
  assign mem.req = read_en_i && (state_q == RO_READ || state_q == RO_CLEAR);
  assign mem.we = (state_q == RO_CLEAR);
  assign mem.addr = addr_q;
  assign mem.wdata = '0;
  assign access = mem.req && mem.gnt;

  assign bin_count_o = mem.rdata;
  assign read_done_o = (state_q == RO_DONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= RO_IDLE;
      addr_q <= '0;
      bin_valid_o <= 1'b0;
    end else begin
      // count shows up the cycle after a granted read
      bin_valid_o <= access && !mem.we;
      case (state_q)
        RO_IDLE: begin
          if (read_en_i) begin
            state_q <= RO_READ;
          end
        end
        RO_READ: begin
          if (access) begin
            state_q <= RO_CLEAR;
          end
        end
        RO_CLEAR: begin
          if (access) begin
            if (addr_q == bin_addr_t'(NUM_BINS - 1)) begin
              state_q <= RO_DONE;
            end else begin
              addr_q <= addr_q + 1'b1;
              state_q <= RO_READ;
            end
          end
        end
        RO_DONE: begin
          addr_q <= '0;
          state_q <= RO_IDLE;
        end
        default: state_q <= RO_IDLE;
      endcase
    end
  end

endmodule

// File: hw/bin_arbiter.sv
`timescale 1ns/1ns

module bin_arbiter (
  input  logic       clk,
  input  logic       rst_n,
  bin_port_if.target accum,
  bin_port_if.target readout
);
  import texture_pkg::*;

  count_t     mem_q [NUM_BINS];
  count_t     rdata_q;
  bin_addr_t  clr_addr_q;
  logic       clearing_q;
  arb_owner_e owner;
  bin_addr_t  sel_addr;
  logic       sel_we;
  count_t     sel_wdata;

  // accumulator has priority and nobody is granted during the clear sweep
  always_comb begin
    owner = OWN_NONE;
    if (!clearing_q) begin
      if (accum.req) begin
        owner = OWN_ACCUM;
      end else if (readout.req) begin
        owner = OWN_READOUT;
      end
    end
  end

  assign accum.gnt = (owner == OWN_ACCUM);
  assign readout.gnt = (owner == OWN_READOUT);

  always_comb begin
    sel_addr = (owner == OWN_ACCUM) ? accum.addr : readout.addr;
    sel_we = (owner == OWN_ACCUM) ? accum.we : readout.we;
    sel_wdata = (owner == OWN_ACCUM) ? accum.wdata : readout.wdata;
  end

  // zero sweep over all bins after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clearing_q <= 1'b1;
      clr_addr_q <= '0;
    end else if (clearing_q) begin
      clr_addr_q <= clr_addr_q + 1'b1;
      if (clr_addr_q == bin_addr_t'(NUM_BINS - 1)) begin
        clearing_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clearing_q) begin
      mem_q[clr_addr_q] <= '0;
    end else if (owner != OWN_NONE) begin
      if (sel_we) begin
        mem_q[sel_addr] <= sel_wdata;
      end else begin
        rdata_q <= mem_q[sel_addr];
      end
    end
  end

  assign accum.rdata = rdata_q;
  assign readout.rdata = rdata_q;

  // a granted access must land inside the bin memory
  a_owner_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (owner != OWN_NONE) |-> (sel_addr < bin_addr_t'(NUM_BINS)))
    else $error("granted address out of range");

endmodule

// File: hw/histogram_accumulator.sv
`timescale 1ns/1ns

module histogram_accumulator (
  input  logic                   clk,
  input  logic                   rst_n,
  input  texture_pkg::bin_addr_t bin_i,
  input  logic                   bin_valid_i,
  input  logic                   bin_last_i,
  bin_port_if.requester          mem,
  output logic                   frame_done_o
);
  import texture_pkg::*;

  // latched descriptor waiting for its read
  logic      rd_pend_q;
  logic      rd_last_q;
  bin_addr_t rd_addr_q;
  // descriptor whose count comes back this cycle
  logic      wr_pend_q;
  logic      wr_last_q;
  bin_addr_t wr_addr_q;

  assign mem.req = rd_pend_q || wr_pend_q;
  assign mem.we = wr_pend_q;
  assign mem.addr = wr_pend_q ? wr_addr_q : rd_addr_q;
  // saturate at the max count
  assign mem.wdata = (mem.rdata == '1) ? mem.rdata : mem.rdata + 1'b1;

  always_ff @(posedge clk) begin
    if (bin_valid_i) begin
      rd_addr_q <= bin_i;
      rd_last_q <= bin_last_i;
    end
    if (rd_pend_q) begin
      wr_addr_q <= rd_addr_q;
      wr_last_q <= rd_last_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      rd_pend_q <= bin_valid_i;
      wr_pend_q <= rd_pend_q && mem.gnt;
      frame_done_o <= wr_pend_q && mem.gnt && wr_last_q;
    end
  end

  // fixed priority in the arbiter, so no descriptor ever waits
  a_same_cycle_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    mem.req |-> mem.gnt)
    else $error("accumulator request not granted");

endmodule

// File: hw/lbp_encoder.sv
`timescale 1ns/1ns

module lbp_encoder (
  input  logic                   clk,
  input  logic                   rst_n,
  window_if.sink                 win,
  output texture_pkg::bin_addr_t bin_o,
  output logic                   bin_valid_o,
  output logic                   bin_last_o
);
  import texture_pkg::*;

  typedef logic [PIX_W+$clog2(RING_N)-1:0] sum_t;

  sum_t ring2_sum;
  logic [RING_N-1:0] ni_pat_d;
  logic [RING_N-1:0] rd_pat_d;
  logic s1_valid_q;
  logic s1_last_q;
  logic s1_ci_q;
  logic [RING_N-1:0] s1_ni_q;
  logic [RING_N-1:0] s1_rd_q;
  code_t ni_code;
  code_t rd_code;
  bin_addr_t bin_d;

  // rotation-invariant uniform mapping, non-uniform patterns go to code 9
  function automatic code_t map_code(input logic [RING_N-1:0] pat);
    logic [RING_N-1:0] trans;
    int ones;
    int flips;
    // bit k against bit k+1, wrapping
    trans = pat ^ {pat[0], pat[RING_N-1:1]};
    ones = $countones(pat);
    flips = $countones(trans);
    if (flips <= 2) begin
      return code_t'(ones);
    end
    return code_t'(NUM_CODES - 1);
  endfunction

  // stage one, comparisons against the ring-2 mean and ring 1
  always_comb begin
    ring2_sum = '0;
    for (int k = 0; k < RING_N; k++) begin
      ring2_sum = ring2_sum + sum_t'(win.ring2[k]);
    end
    for (int k = 0; k < RING_N; k++) begin
      ni_pat_d[k] = (sum_t'(win.ring2[k]) * sum_t'(RING_N)) >= ring2_sum;
      rd_pat_d[k] = win.ring2[k] >= win.ring1[k];
    end
  end

  always_ff @(posedge clk) begin
    if (win.valid) begin
      s1_ci_q <= win.center >= pixel_t'(CI_THRESHOLD);
      s1_ni_q <= ni_pat_d;
      s1_rd_q <= rd_pat_d;
    end
  end

  // stage two, codes and joint bin
  assign ni_code = map_code(s1_ni_q);
  assign rd_code = map_code(s1_rd_q);

  always_comb begin
    bin_d = bin_addr_t'(ni_code) * bin_addr_t'(NUM_CODES) + bin_addr_t'(rd_code);
    if (s1_ci_q) begin
      bin_d = bin_d + bin_addr_t'(NUM_CODES * NUM_CODES);
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid_q) begin
      bin_o <= bin_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s1_last_q <= 1'b0;
      bin_valid_o <= 1'b0;
      bin_last_o <= 1'b0;
    end else begin
      s1_valid_q <= win.valid;
      s1_last_q <= win.valid && win.last;
      bin_valid_o <= s1_valid_q;
      bin_last_o <= s1_last_q;
    end
  end

  a_bin_range: assert property (@(posedge clk) disable iff (!rst_n)
    bin_valid_o |-> (bin_o < bin_addr_t'(NUM_BINS)))
    else $error("bin index out of range");

endmodule

// File: hw/window_buffer.sv
`timescale 1ns/1ns

module window_buffer (
  input  logic                clk,
  input  logic                rst_n,
  input  texture_pkg::pixel_t pixel_i,
  input  logic                pixel_valid_i,
  window_if.source            win
);
  import texture_pkg::*;

  // line_q[0] holds the previous row, line_q[3] the oldest
  pixel_t line_q [WIN_SIZE-1][IMG_COLS];
  // win_q[row][col], row 0 is north, col 0 is west
  pixel_t win_q [WIN_SIZE][WIN_SIZE];
  pixel_t col_pix [WIN_SIZE];
  logic [$clog2(IMG_COLS)-1:0] col_q;
  logic [$clog2(IMG_ROWS)-1:0] row_q;
  logic full_win;
  logic frame_end;

  // new column entering the window, oldest row first
  always_comb begin
    for (int r = 0; r < WIN_SIZE - 1; r++) begin
      col_pix[r] = line_q[WIN_SIZE-2-r][col_q];
    end
    col_pix[WIN_SIZE-1] = pixel_i;
  end

  // incoming pixel is the bottom-right corner of the window
  assign full_win = (row_q >= 2 * WIN_RADIUS) && (col_q >= 2 * WIN_RADIUS);
  assign frame_end = (row_q == IMG_ROWS - 1) && (col_q == IMG_COLS - 1);

  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      line_q[0][col_q] <= pixel_i;
      for (int k = 1; k < WIN_SIZE - 1; k++) begin
        line_q[k][col_q] <= line_q[k-1][col_q];
      end
      for (int r = 0; r < WIN_SIZE; r++) begin
        for (int c = 0; c < WIN_SIZE - 1; c++) begin
          win_q[r][c] <= win_q[r][c+1];
        end
        win_q[r][WIN_SIZE-1] <= col_pix[r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
      win.valid <= 1'b0;
      win.last <= 1'b0;
    end else begin
      win.valid <= pixel_valid_i && full_win;
      win.last <= pixel_valid_i && full_win && frame_end;
      if (pixel_valid_i) begin
        if (col_q == IMG_COLS - 1) begin
          col_q <= '0;
          row_q <= (row_q == IMG_ROWS - 1) ? '0 : row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  // tap the rings out of the register array
  always_comb begin
    win.center = win_q[WIN_RADIUS][WIN_RADIUS];
    for (int k = 0; k < RING_N; k++) begin
      win.ring1[k] = win_q[WIN_RADIUS + DIR_DROW[k]][WIN_RADIUS + DIR_DCOL[k]];
      win.ring2[k] = win_q[WIN_RADIUS + WIN_RADIUS * DIR_DROW[k]]
                          [WIN_RADIUS + WIN_RADIUS * DIR_DCOL[k]];
    end
  end

  // input rule, needed by the RMW in the accumulator
  a_strobe_gap: assert property (@(posedge clk) disable iff (!rst_n)
    pixel_valid_i |=> !pixel_valid_i)
    else $error("pixel strobes in back-to-back cycles");

endmodule

// File: hw/bin_port_if.sv
`timescale 1ns/1ns

interface bin_port_if;
  import texture_pkg::*;

  logic      req;
  logic      we;
  bin_addr_t addr;
  count_t    wdata;
  logic      gnt;
  // valid one cycle after a granted read
  count_t    rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport target (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

// File: hw/window_if.sv
`timescale 1ns/1ns

interface window_if;
  import texture_pkg::*;

  logic   valid;
  pixel_t center;
  ring_t  ring1;
  ring_t  ring2;
  // final full window of the frame
  logic   last;

  modport source (
    output valid, center, ring1, ring2, last
  );

  modport sink (
    input valid, center, ring1, ring2, last
  );

endinterface

// File: hw/texture_pkg.sv
package texture_pkg;

  // frame geometry
  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 16;
  localparam int PIX_W = 8;

  // window shape, outer ring sits at WIN_RADIUS
  localparam int WIN_RADIUS = 2;
  localparam int WIN_SIZE = 2 * WIN_RADIUS + 1;
  localparam int RING_N = 8;

  // ring order: E, NE, N, NW, W, SW, S, SE (row index grows southward)
  localparam int DIR_DROW [RING_N] = '{0, -1, -1, -1, 0, 1, 1, 1};
  localparam int DIR_DCOL [RING_N] = '{1, 1, 0, -1, -1, -1, 0, 1};

  // histogram sizing
  localparam int NUM_CODES = 10;
  localparam int NUM_BINS = 200;
  localparam int BIN_ADDR_W = 8;
  localparam int COUNT_W = 16;

  localparam int CI_THRESHOLD = 128;

  typedef logic [PIX_W-1:0] pixel_t;
  typedef logic [RING_N-1:0][PIX_W-1:0] ring_t;
  typedef logic [3:0] code_t;
  typedef logic [BIN_ADDR_W-1:0] bin_addr_t;
  typedef logic [COUNT_W-1:0] count_t;

  typedef enum logic [1:0] {
    RO_IDLE,
    RO_READ,
    RO_CLEAR,
    RO_DONE
  } readout_state_e;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_ACCUM,
    OWN_READOUT
  } arb_owner_e;

endpackage
